/* source/muldiv_consts.svh */
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Operand and result width
`define MD_XLEN 32

// Destination register tag width
`define MD_TAG_W 5

// Start to multiplier valid: operand stage, five tree stages, output stage
`define MD_MUL_LAT 7

// One quotient bit per iteration
`define MD_DIV_ITER 32

`endif

/* source/muldiv_op_pkg.sv */
`default_nettype none

package muldiv_op_pkg;

	// Encoding matches the RV32M funct3 field
	typedef enum logic [2:0] {
		OP_MUL    = 3'b000,
		OP_MULH   = 3'b001,
		OP_MULHSU = 3'b010,
		OP_MULHU  = 3'b011,
		OP_DIV    = 3'b100,
		OP_DIVU   = 3'b101,
		OP_REM    = 3'b110,
		OP_REMU   = 3'b111
	} md_op_t;

	// Divide and remainder occupy the upper half of the encoding
	function automatic logic is_div(md_op_t op);
		return op[2];
	endfunction

endpackage

`default_nettype wire

/* source/muldiv_result_pkg.sv */
`default_nettype none
`include "muldiv_consts.svh"

package muldiv_result_pkg;

	typedef struct packed {
		logic [`MD_XLEN-1:0] hi;
		logic [`MD_XLEN-1:0] lo;
	} md_halves_t;

	// Double width word, seen whole or as two halves
	typedef union packed {
		logic [2*`MD_XLEN-1:0] full;
		md_halves_t            half;
	} md_wide_u;

	typedef enum logic {
		UNIT_MUL = 1'b0,
		UNIT_DIV = 1'b1
	} md_unit_e;

endpackage

`default_nettype wire

/* source/mul_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_tree #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_valid,
	input  logic [WIDTH-1:0]   i_a,
	input  logic [WIDTH-1:0]   i_b,
	output logic               o_valid,
	output logic [2*WIDTH-1:0] o_product
);
	// One registered adder level per halving of the operand count
	localparam int LEVELS = $clog2(WIDTH);
	localparam int NODES  = WIDTH - 1;

	// Shifted partial products, one per bit of i_b
	logic [2*WIDTH-1:0] pp [WIDTH];

	// Adder nodes in heap order
	// Node k sums children 2k+1 and 2k+2, node 0 is the root
	// Indices at or above NODES refer to partial products
	logic [2*WIDTH-1:0] node [NODES];

	logic [LEVELS-1:0]  vld_pipe;

	for (genvar i = 0; i < WIDTH; i++) begin : gen_pp
		assign pp[i] = i_b[i] ? ({{WIDTH{1'b0}}, i_a} << i) : '0;
	end

	for (genvar k = 0; k < NODES; k++) begin : gen_node
		if (2*k + 1 >= NODES) begin : gen_bottom
			// First level, adds two partial products
			always_ff @(posedge clk) begin
				node[k] <= pp[2*k+1-NODES] + pp[2*k+2-NODES];
			end
		end else begin : gen_upper
			always_ff @(posedge clk) begin
				node[k] <= node[2*k+1] + node[2*k+2];
			end
		end
	end

	// Valid travels beside the sums, one bit per level
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= (vld_pipe << 1) | LEVELS'(i_valid);
		end
	end

	assign o_valid   = vld_pipe[LEVELS-1];
	assign o_product = node[0];

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_consts.svh"

module mul_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	input  muldiv_op_pkg::md_op_t i_op,
	input  logic [`MD_XLEN-1:0]   i_a,
	input  logic [`MD_XLEN-1:0]   i_b,
	input  logic [`MD_TAG_W-1:0]  i_tag,
	output logic                  o_valid,
	output logic [`MD_TAG_W-1:0]  o_tag,
	output logic [`MD_XLEN-1:0]   o_data
);
	import muldiv_op_pkg::*;
	import muldiv_result_pkg::*;

	// Stages spent inside the tree
	localparam int TREE_LAT = `MD_MUL_LAT - 2;

	logic                  a_neg;
	logic                  b_neg;

	logic                  s0_valid;
	logic [`MD_XLEN-1:0]   s0_a;
	logic [`MD_XLEN-1:0]   s0_b;
	logic                  s0_neg;
	logic                  s0_hi;
	logic [`MD_TAG_W-1:0]  s0_tag;

	logic [TREE_LAT-1:0]   neg_pipe;
	logic [TREE_LAT-1:0]   hi_pipe;
	logic [`MD_TAG_W-1:0]  tag_pipe [TREE_LAT];

	logic                  tree_valid;
	logic [2*`MD_XLEN-1:0] tree_product;
	md_wide_u              prod;

	// MULH treats both operands as signed, MULHSU only a
	assign a_neg = ((i_op == OP_MULH) || (i_op == OP_MULHSU)) && i_a[`MD_XLEN-1];
	assign b_neg = (i_op == OP_MULH) && i_b[`MD_XLEN-1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s0_valid <= 1'b0;
			o_valid  <= 1'b0;
		end else begin
			s0_valid <= i_start;
			o_valid  <= tree_valid;
		end
	end

	// Operand stage holds magnitudes only
	always_ff @(posedge clk) begin
		if (i_start) begin
			s0_a   <= a_neg ? -i_a : i_a;
			s0_b   <= b_neg ? -i_b : i_b;
			s0_neg <= a_neg ^ b_neg;
			s0_hi  <= (i_op != OP_MUL);
			s0_tag <= i_tag;
		end
	end

	mul_tree #(
		.WIDTH(`MD_XLEN)
	) mul_tree_i (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (s0_valid),
		.i_a      (s0_a),
		.i_b      (s0_b),
		.o_valid  (tree_valid),
		.o_product(tree_product)
	);

	// Side pipeline kept level with the tree
	always_ff @(posedge clk) begin
		neg_pipe    <= (neg_pipe << 1) | TREE_LAT'(s0_neg);
		hi_pipe     <= (hi_pipe << 1) | TREE_LAT'(s0_hi);
		tag_pipe[0] <= s0_tag;
		for (int i = 1; i < TREE_LAT; i++) begin
			tag_pipe[i] <= tag_pipe[i-1];
		end
	end

	assign prod.full = neg_pipe[TREE_LAT-1] ? -tree_product : tree_product;

	always_ff @(posedge clk) begin
		o_data <= hi_pipe[TREE_LAT-1] ? prod.half.hi : prod.half.lo;
		o_tag  <= tag_pipe[TREE_LAT-1];
	end

	// Tree depth and side pipeline depth agree
	a_tree_align: assert property (@(posedge clk) disable iff (rst)
		tree_valid == $past(s0_valid, TREE_LAT))
		else $error("mul_unit: tree valid out of step with tag pipeline");

endmodule

`default_nettype wire

/* source/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_consts.svh"

module div_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	input  muldiv_op_pkg::md_op_t i_op,
	input  logic [`MD_XLEN-1:0]   i_a,
	input  logic [`MD_XLEN-1:0]   i_b,
	input  logic [`MD_TAG_W-1:0]  i_tag,
	input  logic                  i_grant,
	output logic                  o_busy,
	output logic                  o_done,
	output logic [`MD_TAG_W-1:0]  o_tag,
	output logic [`MD_XLEN-1:0]   o_data
);
	import muldiv_op_pkg::*;
	import muldiv_result_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_FIX,
		S_HOLD
	} state_t;

	localparam int CNT_W = $clog2(`MD_DIV_ITER);

	state_t               state;
	logic [CNT_W-1:0]     iter;

	// hi is the partial remainder, lo shifts dividend out and quotient in
	md_wide_u             rq;
	logic [`MD_XLEN-1:0]  divisor;
	logic [`MD_XLEN-1:0]  dividend;
	logic                 q_neg;
	logic                 r_neg;
	logic                 div_zero;
	logic                 overflow;
	logic                 rem_sel;

	logic                 op_signed;
	logic                 a_neg;
	logic                 b_neg;
	logic [`MD_XLEN+1:0]  trial;
	logic [`MD_XLEN-1:0]  fix_result;

	assign op_signed = (i_op == OP_DIV) || (i_op == OP_REM);
	assign a_neg     = op_signed && i_a[`MD_XLEN-1];
	assign b_neg     = op_signed && i_b[`MD_XLEN-1];

	// Shifted remainder minus divisor, top bit set means it does not fit
	assign trial = {1'b0, rq.half.hi, rq.half.lo[`MD_XLEN-1]} - {2'b00, divisor};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			iter  <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					iter <= '0;
					if (i_start)
						state <= S_RUN;
				end
				S_RUN: begin
					iter <= iter + 1'b1;
					if (iter == CNT_W'(`MD_DIV_ITER - 1))
						state <= S_FIX;
				end
				S_FIX:   state <= S_HOLD;
				S_HOLD: begin
					if (i_grant)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (i_start) begin
					rq.half.hi <= '0;
					rq.half.lo <= a_neg ? -i_a : i_a;
					divisor    <= b_neg ? -i_b : i_b;
					dividend   <= i_a;
					q_neg      <= a_neg ^ b_neg;
					r_neg      <= a_neg;
					div_zero   <= (i_b == '0);
					overflow   <= op_signed && (i_a == {1'b1, {(`MD_XLEN-1){1'b0}}})
						&& (i_b == '1);
					rem_sel    <= (i_op == OP_REM) || (i_op == OP_REMU);
					o_tag      <= i_tag;
				end
			end
			S_RUN: begin
				if (!trial[`MD_XLEN+1]) begin
					rq.half.hi <= trial[`MD_XLEN-1:0];
					rq.half.lo <= {rq.half.lo[`MD_XLEN-2:0], 1'b1};
				end else begin
					rq.full <= {rq.full[2*`MD_XLEN-2:0], 1'b0};
				end
			end
			S_FIX:   o_data <= fix_result;
			default: ;
		endcase
	end

	// RISC-V results for divide by zero and most negative over -1
	always_comb begin
		if (div_zero)
			fix_result = rem_sel ? dividend : '1;
		else if (overflow)
			fix_result = rem_sel ? '0 : dividend;
		else if (rem_sel)
			fix_result = r_neg ? -rq.half.hi : rq.half.hi;
		else
			fix_result = q_neg ? -rq.half.lo : rq.half.lo;
	end

	assign o_busy = (state != S_IDLE);
	assign o_done = (state == S_HOLD);

	// Core only issues a divide while the unit is free
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
		i_start |-> !o_busy)
		else $error("div_unit: divide started while busy");

	// Result waits unchanged for the arbiter
	a_done_held: assert property (@(posedge clk) disable iff (rst)
		o_done && !i_grant |=> o_done && $stable(o_data) && $stable(o_tag))
		else $error("div_unit: result dropped before grant");

endmodule

`default_nettype wire

/* source/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_consts.svh"

module wb_arbiter (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_mul_valid,
	input  logic [`MD_TAG_W-1:0]        i_mul_tag,
	input  logic [`MD_XLEN-1:0]         i_mul_data,
	input  logic                        i_div_done,
	input  logic [`MD_TAG_W-1:0]        i_div_tag,
	input  logic [`MD_XLEN-1:0]         i_div_data,
	output logic                        o_div_grant,
	output logic                        o_wb_valid,
	output logic [`MD_TAG_W-1:0]        o_wb_tag,
	output logic [`MD_XLEN-1:0]         o_wb_data,
	output muldiv_result_pkg::md_unit_e o_wb_unit
);
	import muldiv_result_pkg::*;

	// Multiplier cannot stall, so the divider only gets idle slots
	assign o_div_grant = i_div_done && !i_mul_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_mul_valid || i_div_done;
		end
	end

	always_ff @(posedge clk) begin
		if (i_mul_valid) begin
			o_wb_tag  <= i_mul_tag;
			o_wb_data <= i_mul_data;
			o_wb_unit <= UNIT_MUL;
		end else begin
			o_wb_tag  <= i_div_tag;
			o_wb_data <= i_div_data;
			o_wb_unit <= UNIT_DIV;
		end
	end

	a_grant_excl: assert property (@(posedge clk) disable iff (rst)
		!(o_div_grant && i_mul_valid))
		else $error("wb_arbiter: divider granted over a multiply");

endmodule

`default_nettype wire

/* source/muldiv_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_consts.svh"

module muldiv_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	input  muldiv_op_pkg::md_op_t i_op,
	input  logic [`MD_XLEN-1:0]   i_a,
	input  logic [`MD_XLEN-1:0]   i_b,
	input  logic [`MD_TAG_W-1:0]  i_tag,
	output logic                  o_div_busy,
	output logic                  o_wb_valid,
	output logic [`MD_TAG_W-1:0]  o_wb_tag,
	output logic [`MD_XLEN-1:0]   o_wb_data,
	output logic                  o_wb_src
);
	import muldiv_op_pkg::*;
	import muldiv_result_pkg::*;

	logic                 mul_start;
	logic                 div_start;
	logic                 mul_valid;
	logic [`MD_TAG_W-1:0] mul_tag;
	logic [`MD_XLEN-1:0]  mul_data;
	logic                 div_done;
	logic [`MD_TAG_W-1:0] div_tag;
	logic [`MD_XLEN-1:0]  div_data;
	logic                 div_grant;
	md_unit_e             wb_unit;

	// Steer the start strobe by operation class
	assign mul_start = i_start && !is_div(i_op);
	assign div_start = i_start && is_div(i_op);

	mul_unit mul_unit_i (
		.clk    (clk),
		.rst    (rst),
		.i_start(mul_start),
		.i_op   (i_op),
		.i_a    (i_a),
		.i_b    (i_b),
		.i_tag  (i_tag),
		.o_valid(mul_valid),
		.o_tag  (mul_tag),
		.o_data (mul_data)
	);

	div_unit div_unit_i (
		.clk    (clk),
		.rst    (rst),
		.i_start(div_start),
		.i_op   (i_op),
		.i_a    (i_a),
		.i_b    (i_b),
		.i_tag  (i_tag),
		.i_grant(div_grant),
		.o_busy (o_div_busy),
		.o_done (div_done),
		.o_tag  (div_tag),
		.o_data (div_data)
	);

	wb_arbiter wb_arbiter_i (
		.clk        (clk),
		.rst        (rst),
		.i_mul_valid(mul_valid),
		.i_mul_tag  (mul_tag),
		.i_mul_data (mul_data),
		.i_div_done (div_done),
		.i_div_tag  (div_tag),
		.i_div_data (div_data),
		.o_div_grant(div_grant),
		.o_wb_valid (o_wb_valid),
		.o_wb_tag   (o_wb_tag),
		.o_wb_data  (o_wb_data),
		.o_wb_unit  (wb_unit)
	);

	// High when the divider wrote back
	assign o_wb_src = (wb_unit == UNIT_DIV);

endmodule

`default_nettype wire

/* verif/muldiv_ref_model.svh */
`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

// RV32M results taken straight from the ISA rules, selected by funct3

function automatic logic [31:0] ref_mul(input logic [2:0] funct3, input logic [31:0] a,
		input logic [31:0] b);
	logic [63:0] ext_a;
	logic [63:0] ext_b;
	logic [63:0] product;
	// MULH extends both operands by sign, MULHSU only rs1
	ext_a = {32'b0, a};
	ext_b = {32'b0, b};
	if ((funct3 == 3'b001 || funct3 == 3'b010) && a[31])
		ext_a[63:32] = '1;
	if (funct3 == 3'b001 && b[31])
		ext_b[63:32] = '1;
	product = ext_a * ext_b;
	return (funct3 == 3'b000) ? product[31:0] : product[63:32];
endfunction

function automatic logic [31:0] ref_div(input logic [2:0] funct3, input logic [31:0] a,
		input logic [31:0] b);
	logic        is_rem;
	logic        is_signed;
	logic [31:0] result;
	is_rem    = funct3[1];
	is_signed = !funct3[0];
	if (b == 32'd0)
		result = is_rem ? a : 32'hffff_ffff;
	else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff)
		result = is_rem ? 32'd0 : a;
	else if (is_signed && is_rem)
		result = $signed(a) % $signed(b);
	else if (is_signed)
		result = $signed(a) / $signed(b);
	else
		result = is_rem ? a % b : a / b;
	return result;
endfunction

function automatic logic [31:0] ref_result(input logic [2:0] funct3, input logic [31:0] a,
		input logic [31:0] b);
	return funct3[2] ? ref_div(funct3, a, b) : ref_mul(funct3, a, b);
endfunction

`endif

/* verif/muldiv_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_consts.svh"

module muldiv_tb;
	import muldiv_op_pkg::*;

	`include "muldiv_ref_model.svh"

	localparam int CLK_PERIOD = 4;
	localparam int N_OPS      = 600;
	localparam int N_DIRECTED = 6;
	// Start cycle to writeback cycle
	localparam int MUL_WB_LAT = `MD_MUL_LAT + 1;
	localparam int DIV_WB_MIN = `MD_DIV_ITER + 3;
	localparam int WATCHDOG   = N_OPS * 40;

	logic        clk;
	logic        rst;
	logic        i_start;
	md_op_t      i_op;
	logic [31:0] i_a;
	logic [31:0] i_b;
	logic [4:0]  i_tag;
	logic        o_div_busy;
	logic        o_wb_valid;
	logic [4:0]  o_wb_tag;
	logic [31:0] o_wb_data;
	logic        o_wb_src;

	int          cycle = 0;
	logic [15:0] lfsr = 16'd40827;

	// Expected results per tag
	bit          pending [32];
	bit          exp_div [32];
	logic [31:0] exp_data [32];
	int          exp_cyc [32];
	int          n_pending = 0;
	bit          div_out = 1'b0;
	int          div_cyc = 0;
	int          err_data = 0;
	int          err_timing = 0;
	int          err_book = 0;

	muldiv_top muldiv_top_i (
		.clk       (clk),
		.rst       (rst),
		.i_start   (i_start),
		.i_op      (i_op),
		.i_a       (i_a),
		.i_b       (i_b),
		.i_tag     (i_tag),
		.o_div_busy(o_div_busy),
		.o_wb_valid(o_wb_valid),
		.o_wb_tag  (o_wb_tag),
		.o_wb_data (o_wb_data),
		.o_wb_src  (o_wb_src)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return bits;
	endfunction

	// Corner values about one time in eight
	function automatic logic [31:0] draw_operand();
		logic [31:0] v;
		if (take_bits(3) == 32'd0) begin
			case (take_bits(2))
				32'd0:   v = 32'd0;
				32'd1:   v = 32'hffff_ffff;
				32'd2:   v = 32'h8000_0000;
				default: v = 32'd1;
			endcase
		end else begin
			v = take_bits(32);
		end
		return v;
	endfunction

	function automatic int find_free_tag(input logic [4:0] first);
		logic [4:0] t;
		int         found;
		found = -1;
		for (int i = 31; i >= 0; i--) begin
			t = first + 5'(i);
			if (!pending[t])
				found = int'(t);
		end
		return found;
	endfunction

	// Overflow and divide by zero cases up front
	task automatic directed_case(input int idx, output logic [2:0] op, output logic [31:0] a,
			output logic [31:0] b);
		case (idx)
			0:       {op, a, b} = {OP_DIV, 32'h8000_0000, 32'hffff_ffff};
			1:       {op, a, b} = {OP_REM, 32'h8000_0000, 32'hffff_ffff};
			2:       {op, a, b} = {OP_DIVU, 32'd123, 32'd0};
			3:       {op, a, b} = {OP_REMU, 32'd123, 32'd0};
			4:       {op, a, b} = {OP_DIV, 32'hffff_fff9, 32'd0};
			default: {op, a, b} = {OP_REM, 32'hffff_fff9, 32'd2};
		endcase
	endtask

	task automatic issue(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [4:0] tag);
		i_start       <= 1'b1;
		i_op          <= md_op_t'(op);
		i_a           <= a;
		i_b           <= b;
		i_tag         <= tag;
		pending[tag]  = 1'b1;
		exp_div[tag]  = op[2];
		exp_data[tag] = ref_result(op, a, b);
		// The DUT sees the start in the following cycle count
		exp_cyc[tag]  = cycle + 1;
		n_pending++;
		if (op[2]) begin
			div_out = 1'b1;
			div_cyc = cycle + 1;
		end
	endtask

	task automatic finish_run();
		$display("Errors: data %0d, timing %0d, bookkeeping %0d", err_data, err_timing, err_book);
		if (err_data + err_timing + err_book == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin : stimulus
		logic [2:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		int          tag;
		int          issued;
		bit          idle;
		clk     = 1'b0;
		rst     = 1'b1;
		i_start = 1'b0;
		i_op    = OP_MUL;
		i_a     = '0;
		i_b     = '0;
		i_tag   = '0;
		issued  = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		while (issued < N_OPS) begin
			@(posedge clk);
			i_start <= 1'b0;
			if (issued < N_DIRECTED) begin
				directed_case(issued, op, a, b);
				idle = 1'b0;
			end else begin
				op   = 3'(take_bits(3));
				a    = draw_operand();
				b    = draw_operand();
				idle = (take_bits(2) == 32'd0);
			end
			tag = find_free_tag(5'(take_bits(5)));
			// A divide waits until the divider is free
			if (!idle && tag >= 0 && !(op[2] && div_out)) begin
				issue(op, a, b, 5'(tag));
				issued++;
			end
		end
		@(posedge clk);
		i_start <= 1'b0;
		while (n_pending != 0)
			@(posedge clk);
		// Catch stray writebacks after the last result
		repeat (12) @(posedge clk);
		finish_run();
	end

	always @(negedge clk) begin : monitor
		logic [4:0] t;
		if (!rst) begin
			t = o_wb_tag;
			if (o_wb_valid) begin
				assert (pending[t]) else begin
					err_book++;
					$display("Writeback at %0t ns for tag %0d, which had no outstanding operation",
						$time, t);
				end
			end
			if (o_wb_valid && pending[t]) begin
				assert (o_wb_data === exp_data[t]) else begin
					err_data++;
					$display("error %0t ns: tag %0d data %h, expected %h",
						$time, t, o_wb_data, exp_data[t]);
				end
				assert (o_wb_src === exp_div[t]) else begin
					err_data++;
					$display("error %0t ns: tag %0d source %b, expected %b",
						$time, t, o_wb_src, exp_div[t]);
				end
				if (exp_div[t]) begin
					assert (cycle >= exp_cyc[t] + DIV_WB_MIN) else begin
						err_timing++;
						$display("error %0t ns: divide tag %0d written back after %0d cycles",
							$time, t, cycle - exp_cyc[t]);
					end
					div_out = 1'b0;
				end else begin
					assert (cycle == exp_cyc[t] + MUL_WB_LAT) else begin
						err_timing++;
						$display("error %0t ns: multiply tag %0d written back after %0d cycles",
							$time, t, cycle - exp_cyc[t]);
					end
				end
				pending[t] = 1'b0;
				n_pending--;
			end
			// A late divide must have lost every slot to a multiply
			if (div_out && cycle >= div_cyc + DIV_WB_MIN) begin
				assert (o_wb_valid && o_wb_src === 1'b0) else begin
					err_timing++;
					$display("error %0t ns: divide result held while writeback was free", $time);
				end
			end
			assert (o_div_busy === (div_out && cycle != div_cyc)) else begin
				err_data++;
				$display("error %0t ns: o_div_busy %b with divide outstanding %b",
					$time, o_div_busy, div_out);
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG) @(posedge clk);
		$display("Simulation timed out after %0d cycles with %0d operations outstanding",
			WATCHDOG, n_pending);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* klara_muldiv.f */
+incdir+source
+incdir+verif
source/muldiv_op_pkg.sv
source/muldiv_result_pkg.sv
source/mul_tree.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/muldiv_top.sv
verif/muldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module muldiv_tb \
	-f klara_muldiv.f -o muldiv_sim \
	&& ./obj_dir/muldiv_sim | tee /dev/stderr | grep -q "Test completed successfully" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
